//--- video_top.f
source/video_pkg.sv
source/video_regs.sv
source/video_timing.sv
source/pixel_fifo.sv
source/video_control.sv
source/video_top.sv
bench/video_clock.sv
bench/video_asserts.sv
bench/video_tb.sv

//--- run.sh
#!/bin/bash
# Build and run the video controller simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module video_tb \
    -f video_top.f \
    -o video_sim

./obj_dir/video_sim

//--- bench/video_tb.sv
`timescale 1ns/1ps

module video_tb;

    localparam int fifo_depth = 16;
    localparam int pcnt_val   = 1;
    localparam int wait_limit = 100;   // Cycles per handshake

    logic        clk;
    logic        reset_n;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        hsync;
    logic        hblank;
    logic        vsync;
    logic        vblank;
    logic [7:0]  r;
    logic [7:0]  g;
    logic [7:0]  b;

    integer      seed = 32'hea75_7b11;
    logic [23:0] pixel_q[$];   // Pixels accepted by the FIFO in push order
    int          act_cnt;
    logic [23:0] exp_pix;

    video_clock u_clock (.clk(clk));

    video_top #(.fifo_depth(fifo_depth)) DUT (.*);

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        int n;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        n = 0;
        while (!(awready && wready)) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) stop_run("Write address/data handshake never came");
        end
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) stop_run("Write response never came");
        end
        check_value("bresp", 32'(bresp), 32'(exp_resp));
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) stop_run("Read address handshake never came");
        end
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        n = 0;
        while (!rvalid) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) stop_run("Read data never came");
        end
        check_value("rdata", rdata, exp_data);
        check_value("rresp", 32'(rresp), 32'(exp_resp));
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic wait_frames(input int frames);
        int n;
        int seen;
        logic prev;
        n = 0;
        seen = 0;
        prev = vblank;
        while (seen < frames) begin
            @(negedge clk);
            if (vblank && !prev) seen++;
            prev = vblank;
            n++;
            if (n > frames * 1000) stop_run("Frame end never came");
        end
    endtask

    // Shown pixels follow the push queue and turn black once it runs dry
    always @(negedge clk) begin
        if (reset_n && !hblank && !vblank) begin
            if (act_cnt % (pcnt_val + 1) == 0) begin
                exp_pix = (pixel_q.size() > 0) ? pixel_q.pop_front() : 24'h0;
                check_value("rgb", 32'({r, g, b}), 32'(exp_pix));
            end
            act_cnt++;
        end else begin
            act_cnt = 0;
        end
    end

    initial begin
        logic [31:0] data;
        reset_n = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        act_cnt = 0;
        repeat (4) @(posedge clk);
        #1;
        reset_n = 1'b1;
        @(posedge clk);
        #1;

        axi_write(8'h00, 32'h0000_0010, 2'b00);   // pcnt 1 with raster off
        axi_write(8'h28, (32'd8 << 13) | 32'd14, 2'b00);
        axi_write(8'h30, (32'd10 << 13) | 32'd13, 2'b00);
        axi_write(8'h38, (32'd4 << 13) | 32'd6, 2'b00);
        axi_write(8'h40, (32'd5 << 13) | 32'd6, 2'b00);
        axi_read(8'h00, 32'h0000_0010, 2'b00);
        axi_read(8'h28, (32'd8 << 13) | 32'd14, 2'b00);
        axi_read(8'h30, (32'd10 << 13) | 32'd13, 2'b00);
        axi_read(8'h38, (32'd4 << 13) | 32'd6, 2'b00);
        axi_read(8'h40, (32'd5 << 13) | 32'd6, 2'b00);
        axi_read(8'h04, 32'h0, 2'b10);             // Unmapped
        axi_write(8'h04, 32'h1234, 2'b10);
        axi_read(8'h50, 32'h1, 2'b00);             // Empty

        for (int i = 0; i <= fifo_depth; i++) begin
            data = $random(seed);
            if (i < fifo_depth) begin
                axi_write(8'h48, data, 2'b00);
                pixel_q.push_back(data[23:0]);
            end else begin
                axi_write(8'h48, data, 2'b10);     // FIFO full
            end
        end
        axi_read(8'h50, 32'h2, 2'b00);

        axi_write(8'h00, 32'h0000_0018, 2'b00);   // Enable raster
        wait_frames(3);
        @(posedge clk);
        #1;
        check_value("queue left", 32'(pixel_q.size()), 32'd0);
        axi_read(8'h50, 32'h5, 2'b00);             // Empty with underflow

        data = $random(seed);
        axi_write(8'h48, data, 2'b00);             // Sits in the FIFO until the flush
        axi_read(8'h50, 32'h4, 2'b00);
        axi_write(8'h00, 32'h0000_0010, 2'b00);   // Flushes the FIFO
        axi_read(8'h50, 32'h1, 2'b00);
        @(negedge clk);
        check_value("blank/sync", {28'b0, hblank, vblank, hsync, vsync}, 32'hC);

        $display("TEST OK");
        $finish;
    end

endmodule

//--- bench/video_asserts.sv
`timescale 1ns/1ps

module video_asserts (
    input logic                   clk,
    input logic                   reset_n,
    input video_pkg::timing_cfg_t cfg,
    input logic                   pixel_tick,
    input logic                   hsync,
    input logic                   hblank,
    input logic                   vsync,
    input logic                   vblank,
    input logic [7:0]             r,
    input logic [7:0]             g,
    input logic [7:0]             b
);
    import video_pkg::*;

    logic [31:0] line_clks;
    logic [31:0] hs_width;
    logic [31:0] hb_width;
    logic [31:0] hs_gap;
    logic [31:0] hs_run;
    logic [31:0] hb_run;
    logic [31:0] vs_lines;
    logic [31:0] vb_lines;
    logic        hs_q;
    logic        hs_seen;
    logic        hb_low_q;
    logic        vs_q;
    logic        vb_low_q;
    logic        hs_rise;

    // Expected lengths in clocks, from the programmed fields
    assign line_clks = (32'(cfg.h1.lo) + 1) * (32'(cfg.pcnt) + 1);
    assign hs_width  = (32'(cfg.h2.lo) - 32'(cfg.h2.hi)) * (32'(cfg.pcnt) + 1);
    assign hb_width  = 32'(cfg.h1.hi) * (32'(cfg.pcnt) + 1);
    assign hs_rise   = hsync && !hs_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n || !cfg.en) begin
            hs_q     <= 1'b0;
            hs_seen  <= 1'b0;
            hs_gap   <= '0;
            hs_run   <= '0;
            hb_run   <= '0;
            hb_low_q <= 1'b0;
            vs_q     <= 1'b0;
            vb_low_q <= 1'b0;
            vs_lines <= '0;
            vb_lines <= '0;
        end else begin
            hs_q     <= hsync;
            hb_low_q <= !hblank;
            vs_q     <= vsync;
            vb_low_q <= !vblank;
            if (hs_rise) begin
                hs_gap  <= 32'd1;   // Restart line period count
                hs_seen <= 1'b1;
            end else begin
                hs_gap <= hs_gap + 32'd1;
            end
            hs_run <= hsync ? hs_run + 32'd1 : '0;
            hb_run <= !hblank ? hb_run + 32'd1 : '0;
            if (!vsync) begin
                vs_lines <= '0;
            end else if (hs_rise) begin
                vs_lines <= vs_lines + 32'd1;
            end
            if (vblank) begin
                vb_lines <= '0;
            end else if (hs_rise) begin
                vb_lines <= vb_lines + 32'd1;
            end
        end
    end

    hsync_period: assert property (@(posedge clk) disable iff (!reset_n || !cfg.en)
        (hs_rise && hs_seen) |-> (hs_gap == line_clks))
        else $error("hsync period %0d, expected %0d", hs_gap, line_clks);

    hsync_width: assert property (@(posedge clk) disable iff (!reset_n || !cfg.en)
        (hs_q && !hsync) |-> (hs_run == hs_width))
        else $error("hsync width %0d, expected %0d", hs_run, hs_width);

    hblank_width: assert property (@(posedge clk) disable iff (!reset_n || !cfg.en)
        (hb_low_q && hblank) |-> (hb_run == hb_width))
        else $error("hblank low for %0d clocks, expected %0d", hb_run, hb_width);

    vsync_lines: assert property (@(posedge clk) disable iff (!reset_n || !cfg.en)
        (vs_q && !vsync) |-> (vs_lines == 32'(cfg.v2.lo) - 32'(cfg.v2.hi)))
        else $error("vsync lasted %0d lines", vs_lines);

    vblank_lines: assert property (@(posedge clk) disable iff (!reset_n || !cfg.en)
        (vb_low_q && vblank) |-> (vb_lines == 32'(cfg.v1.hi)))
        else $error("vblank low for %0d lines", vb_lines);

    // Colour only moves on the clock after a pixel tick
    pixel_hold: assert property (@(posedge clk) disable iff (!reset_n || !cfg.en)
        (!hblank && !vblank && $past(!hblank && !vblank) && !$past(pixel_tick))
        |-> $stable({r, g, b}))
        else $error("RGB changed inside a pixel period");

endmodule

bind video_top video_asserts u_asserts (
    .clk        (clk),
    .reset_n    (reset_n),
    .cfg        (cfg),
    .pixel_tick (scan.pixel_tick),
    .hsync      (hsync),
    .hblank     (hblank),
    .vsync      (vsync),
    .vblank     (vblank),
    .r          (r),
    .g          (g),
    .b          (b)
);

//--- bench/video_clock.sv
`timescale 1ns/1ps

module video_clock #(
    parameter int half_period = 5   // 10 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

//--- source/video_top.sv
`timescale 1ns/1ps

module video_top #(
    parameter int fifo_depth = 16
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic [7:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic        hsync,
    output logic        hblank,
    output logic        vsync,
    output logic        vblank,
    output logic [7:0]  r,
    output logic [7:0]  g,
    output logic [7:0]  b
);
    import video_pkg::*;

    timing_cfg_t cfg;
    scan_t       scan;
    pixel_t      push_pixel;
    pixel_t      head;
    logic        push;
    logic        pop;
    logic        flush;
    logic        full;
    logic        empty;
    logic        underflow;

    video_regs u_regs (
        .clk        (clk),
        .reset_n    (reset_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .full       (full),
        .empty      (empty),
        .underflow  (underflow),
        .cfg        (cfg),
        .push       (push),
        .push_pixel (push_pixel)
    );

    video_timing u_timing (
        .clk     (clk),
        .reset_n (reset_n),
        .cfg     (cfg),
        .scan    (scan)
    );

    pixel_fifo #(
        .depth (fifo_depth)
    ) u_fifo (
        .clk        (clk),
        .reset_n    (reset_n),
        .push       (push),
        .push_pixel (push_pixel),
        .pop        (pop),
        .flush      (flush),
        .head       (head),
        .full       (full),
        .empty      (empty)
    );

    video_control u_control (
        .clk       (clk),
        .reset_n   (reset_n),
        .cfg       (cfg),
        .scan      (scan),
        .head      (head),
        .empty     (empty),
        .pop       (pop),
        .flush     (flush),
        .underflow (underflow),
        .hsync     (hsync),
        .hblank    (hblank),
        .vsync     (vsync),
        .vblank    (vblank),
        .r         (r),
        .g         (g),
        .b         (b)
    );

endmodule

//--- source/video_control.sv
`timescale 1ns/1ps

module video_control (
    input  logic                   clk,
    input  logic                   reset_n,
    input  video_pkg::timing_cfg_t cfg,
    input  video_pkg::scan_t       scan,
    input  video_pkg::pixel_t      head,
    input  logic                   empty,
    output logic                   pop,
    output logic                   flush,
    output logic                   underflow,
    output logic                   hsync,
    output logic                   hblank,
    output logic                   vsync,
    output logic                   vblank,
    output logic [7:0]             r,
    output logic [7:0]             g,
    output logic [7:0]             b
);
    import video_pkg::*;

    logic   en_q;
    logic   fetch;   // New pixel due this cycle
    pixel_t pix;

    assign fetch = scan.pixel_tick && scan.active;
    assign flush = en_q && !cfg.en;   // Falling en
    assign pop   = fetch && !empty;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            en_q <= 1'b0;
        end else begin
            en_q <= cfg.en;
        end
    end

    // Scan and pixel registered on the same edge
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hsync  <= 1'b0;
            hblank <= 1'b1;
            vsync  <= 1'b0;
            vblank <= 1'b1;
            pix    <= '0;
        end else begin
            hsync  <= scan.hsync;
            hblank <= scan.hblank;
            vsync  <= scan.vsync;
            vblank <= scan.vblank;
            if (!scan.active) begin
                pix <= '0;
            end else if (fetch) begin
                pix <= empty ? '0 : head;   // Black on underrun
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            underflow <= 1'b0;
        end else if (flush) begin
            underflow <= 1'b0;
        end else if (fetch && empty) begin
            underflow <= 1'b1;   // Sticky
        end
    end

    assign r = pix.r;
    assign g = pix.g;
    assign b = pix.b;

endmodule

//--- source/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo #(
    parameter int depth = 16   // Power of two
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              push,
    input  video_pkg::pixel_t push_pixel,
    input  logic              pop,
    input  logic              flush,
    output video_pkg::pixel_t head,
    output logic              full,
    output logic              empty
);
    import video_pkg::*;

    localparam int aw = $clog2(depth);

    pixel_t      mem [depth];
    logic [aw:0] wr_ptr;   // Extra bit tells full from empty
    logic [aw:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[aw-1:0]] <= push_pixel;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign head  = mem[rd_ptr[aw-1:0]];   // Show-ahead read
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

endmodule

//--- source/video_timing.sv
`timescale 1ns/1ps

module video_timing (
    input  logic                   clk,
    input  logic                   reset_n,
    input  video_pkg::timing_cfg_t cfg,
    output video_pkg::scan_t       scan
);
    import video_pkg::*;

    logic [5:0] div_cnt;
    logic       step;       // Last clock of the pixel period
    coord_t     h_cnt;
    coord_t     v_cnt;
    coord_t     hsize;
    coord_t     hend;
    coord_t     hs_start;
    coord_t     hs_end;
    coord_t     vsize;
    coord_t     vend;
    coord_t     vs_start;
    coord_t     vs_end;

    assign hsize    = cfg.h1.hi;
    assign hend     = cfg.h1.lo;
    assign hs_start = cfg.h2.hi;
    assign hs_end   = cfg.h2.lo;
    assign vsize    = cfg.v1.hi;
    assign vend     = cfg.v1.lo;
    assign vs_start = cfg.v2.hi;
    assign vs_end   = cfg.v2.lo;

    assign step = (div_cnt == cfg.pcnt);

    // Pixel divider, period pcnt+1 clocks
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
        end else if (!cfg.en || step) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 6'd1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (!cfg.en) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (step) begin
            if (h_cnt >= hend) begin   // End of line
                h_cnt <= '0;
                v_cnt <= (v_cnt >= vend) ? '0 : v_cnt + coord_t'(1);
            end else begin
                h_cnt <= h_cnt + coord_t'(1);
            end
        end
    end

    // Disabled raster shows blank with syncs low
    always_comb begin
        scan.pixel_tick = cfg.en && (div_cnt == 6'd0);
        scan.active     = cfg.en && (h_cnt < hsize) && (v_cnt < vsize);
        scan.hsync      = cfg.en && (h_cnt >= hs_start) && (h_cnt < hs_end);
        scan.vsync      = cfg.en && (v_cnt >= vs_start) && (v_cnt < vs_end);
        scan.hblank     = !cfg.en || (h_cnt >= hsize);
        scan.vblank     = !cfg.en || (v_cnt >= vsize);
    end

endmodule

//--- source/video_regs.sv
`timescale 1ns/1ps

module video_regs (
    input  logic                     clk,
    input  logic                     reset_n,

    input  logic [7:0]               awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [31:0]              wdata,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [7:0]               araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [31:0]              rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,

    input  logic                     full,
    input  logic                     empty,
    input  logic                     underflow,
    output video_pkg::timing_cfg_t   cfg,
    output logic                     push,
    output video_pkg::pixel_t        push_pixel
);
    import video_pkg::*;

    wdata_u      wword;
    ctrl_t       wctrl;
    ctrl_t       rctrl;
    logic        wr_go;
    logic        wr_fire;
    logic        wr_pixel;
    logic        wr_mapped;
    logic        rd_fire;
    logic        rd_mapped;
    logic [31:0] rd_word;

    assign wword = wdata;
    assign wctrl = wdata;

    // Both channels must be valid, one write in flight at a time
    assign wr_go    = awvalid && wvalid && !awready && !bvalid;
    assign wr_fire  = awvalid && awready && wvalid && wready;
    assign wr_pixel = wr_fire && (awaddr == reg_pixel_addr);

    assign push       = wr_pixel && !full;   // Dropped when full
    assign push_pixel = wword.as_pixel.pixel;

    always_comb begin
        case (awaddr)
            reg_ctrl_addr, reg_h1_addr, reg_h2_addr, reg_v1_addr,
            reg_v2_addr, reg_pixel_addr, reg_status_addr: wr_mapped = 1'b1;
            default:                                      wr_mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= wr_go;   // One-cycle ready pulse
            wready  <= wr_go;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= (!wr_mapped || (wr_pixel && full)) ? 2'b10 : 2'b00;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cfg <= '0;
        end else if (wr_fire) begin
            case (awaddr)
                reg_ctrl_addr: begin
                    cfg.en   <= wctrl.en;
                    cfg.pcnt <= wctrl.pcnt;
                end
                reg_h1_addr: cfg.h1 <= wword.as_span.span;
                reg_h2_addr: cfg.h2 <= wword.as_span.span;
                reg_v1_addr: cfg.v1 <= wword.as_span.span;
                reg_v2_addr: cfg.v2 <= wword.as_span.span;
                default: ;   // Status write ignored
            endcase
        end
    end

    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;

    always_comb begin
        rctrl      = '0;
        rctrl.en   = cfg.en;
        rctrl.pcnt = cfg.pcnt;
        rd_word    = '0;
        rd_mapped  = 1'b1;
        case (araddr)
            reg_ctrl_addr:   rd_word = rctrl;
            reg_h1_addr:     rd_word = {6'b0, cfg.h1};
            reg_h2_addr:     rd_word = {6'b0, cfg.h2};
            reg_v1_addr:     rd_word = {6'b0, cfg.v1};
            reg_v2_addr:     rd_word = {6'b0, cfg.v2};
            reg_pixel_addr:  rd_word = '0;   // Write-only
            reg_status_addr: rd_word = {29'b0, underflow, full, empty};
            default:         rd_mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_mapped ? 2'b00 : 2'b10;
        end
    end

endmodule

//--- source/video_pkg.sv
package video_pkg;

    // Register map, byte offsets on the AXI4-Lite port
    localparam logic [7:0] reg_ctrl_addr   = 8'h00;
    localparam logic [7:0] reg_h1_addr     = 8'h28;
    localparam logic [7:0] reg_h2_addr     = 8'h30;
    localparam logic [7:0] reg_v1_addr     = 8'h38;
    localparam logic [7:0] reg_v2_addr     = 8'h40;
    localparam logic [7:0] reg_pixel_addr  = 8'h48;
    localparam logic [7:0] reg_status_addr = 8'h50;

    localparam int coord_w = 13;   // Width of every timing coordinate

    typedef logic [coord_w-1:0] coord_t;

    typedef struct packed {
        logic [7:0] r;   // Word bits 23:16
        logic [7:0] g;   // Word bits 15:8
        logic [7:0] b;   // Word bits 7:0
    } pixel_t;

    // h1/v1: hi = display size, lo = total minus one
    // h2/v2: hi = sync start, lo = sync end
    typedef struct packed {
        coord_t hi;   // Bits 25:13
        coord_t lo;   // Bits 12:0
    } span_t;

    typedef struct packed {
        logic [5:0] pad;
        span_t      span;
    } span_word_t;

    typedef struct packed {
        logic [7:0] pad;
        pixel_t     pixel;
    } pixel_word_t;

    // One bus write word, seen as timing span or as pixel
    typedef union packed {
        span_word_t  as_span;
        pixel_word_t as_pixel;
    } wdata_u;

    typedef struct packed {
        logic [21:0] pad_hi;
        logic [5:0]  pcnt;     // Pixel divider, bits 9:4
        logic        en;       // Controller enable, bit 3
        logic [2:0]  pad_lo;
    } ctrl_t;

    typedef struct packed {
        logic       en;
        logic [5:0] pcnt;
        span_t      h1;
        span_t      h2;
        span_t      v1;
        span_t      v2;
    } timing_cfg_t;

    typedef struct packed {
        logic pixel_tick;   // First clock of a pixel period
        logic active;
        logic hsync;
        logic vsync;
        logic hblank;
        logic vblank;
    } scan_t;

endpackage
